// ==== cnn_pkg.sv ====
package cnn_pkg;

    // window geometry, fixed by the enable decoder table
    localparam int window_len = 25;
    localparam int cnt_w      = 5;
    localparam int lane_n     = 4;

    // register map, byte addresses on the axi4-lite slave
    localparam int addr_w = 8;
    localparam logic [addr_w-1:0] reg_sample_addr   = 8'h00;
    localparam logic [addr_w-1:0] reg_ctrl_addr     = 8'h04;
    localparam logic [addr_w-1:0] reg_status_addr   = 8'h08;
    // lane i sits at base + 4*i
    localparam logic [addr_w-1:0] reg_acc_base_addr = 8'h10;

    // axi response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // sample register view of the write data word
    typedef struct packed {
        logic [15:0]       rsvd;
        logic signed [7:0] weight;
        logic signed [7:0] feature;
    } sample_s;

    // control register view, only bit 0 has a meaning
    typedef struct packed {
        logic [30:0] rsvd;
        logic        clear;
    } cmd_s;

    // one write data word, decoded by address
    typedef union packed {
        sample_s sample;
        cmd_s    cmd;
    } data_word_u;

    // accepted sample handed from the write port to the mac array
    typedef struct packed {
        logic              valid;
        logic signed [7:0] feature;
        logic signed [7:0] weight;
    } sample_ev_s;

    // window progress seen by both bus ports
    typedef struct packed {
        logic             done;
        logic [cnt_w-1:0] cnt;
    } status_s;

endpackage

// ==== feature_weight_en_decoder.sv ====
module feature_weight_en_decoder (
    input  logic [cnn_pkg::cnt_w-1:0]  cnt,
    output logic [cnn_pkg::lane_n-1:0] buff_en
);

    // window position to output buffer map
    // bit 3 is buffer 3, a position can feed several buffers at once
    always_comb begin
        case (cnt)
            5'd0:    buff_en = 4'b1000;
            5'd1:    buff_en = 4'b0100;
            5'd2:    buff_en = 4'b0010;
            5'd3:    buff_en = 4'b0001;
            5'd4:    buff_en = 4'b1000;
            // overlap region between neighbouring windows
            5'd5:    buff_en = 4'b1100;
            5'd6:    buff_en = 4'b0110;
            5'd7:    buff_en = 4'b0010;
            5'd8:    buff_en = 4'b1001;
            5'd9:    buff_en = 4'b1101;
            5'd10:   buff_en = 4'b1000;
            5'd11:   buff_en = 4'b1110;
            5'd12:   buff_en = 4'b0100;
            5'd13:   buff_en = 4'b0110;
            5'd14:   buff_en = 4'b0010;
            5'd15:   buff_en = 4'b0011;
            5'd16:   buff_en = 4'b1011;
            5'd17:   buff_en = 4'b0001;
            5'd18:   buff_en = 4'b1101;
            5'd19:   buff_en = 4'b1000;
            5'd20:   buff_en = 4'b1100;
            5'd21:   buff_en = 4'b0010;
            5'd22:   buff_en = 4'b0011;
            5'd23:   buff_en = 4'b1001;
            // last position of the 5x5 window
            5'd24:   buff_en = 4'b1000;
            // past the window nothing accumulates
            default: buff_en = 4'b0000;
        endcase
    end

endmodule

// ==== axil_write_port.sv ====
module axil_write_port (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cnn_pkg::addr_w-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  cnn_pkg::data_word_u        wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  cnn_pkg::status_s           status,
    output cnn_pkg::sample_ev_s        sample_ev,
    output logic                       clear
);
    import cnn_pkg::*;

    logic              wr_accept;
    logic              hit_sample;
    logic              hit_ctrl;
    logic              sample_ok;
    logic              ev_valid;
    logic signed [7:0] ev_feature;
    logic signed [7:0] ev_weight;

    // address and data are taken together, never while a response is pending
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign hit_sample = (awaddr == reg_sample_addr);
    assign hit_ctrl   = (awaddr == reg_ctrl_addr);
    // a full window refuses further samples
    assign sample_ok  = hit_sample && !status.done;

    // control side: response handshake, event strobe, clear pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid   <= 1'b0;
            ev_valid <= 1'b0;
            clear    <= 1'b0;
        end else begin
            // strobes last exactly one cycle
            ev_valid <= wr_accept && sample_ok;
            clear    <= wr_accept && hit_ctrl && wdata.cmd.clear;
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // payload side, qualified by bvalid and ev_valid
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp      <= (sample_ok || hit_ctrl) ? resp_okay : resp_slverr;
            ev_feature <= wdata.sample.feature;
            ev_weight  <= wdata.sample.weight;
        end
    end

    assign sample_ev = '{valid: ev_valid, feature: ev_feature, weight: ev_weight};

endmodule

// ==== window_mac_array.sv ====
module window_mac_array #(
    parameter int acc_w = 20
) (
    input  logic                                           clk,
    input  logic                                           arst_n,
    input  cnn_pkg::sample_ev_s                            sample_ev,
    input  logic                                           clear,
    output logic signed [cnn_pkg::lane_n-1:0][acc_w-1:0]   acc,
    output cnn_pkg::status_s                               status
);
    import cnn_pkg::*;

    logic [lane_n-1:0]  buff_en;
    logic signed [15:0] product;
    logic [cnt_w-1:0]   cnt;
    logic               done;

    // enables follow the count held before the update edge
    feature_weight_en_decoder en_dec_i (
        .cnt     (cnt),
        .buff_en (buff_en)
    );

    // one shared multiplier, every lane sees the same product
    assign product = sample_ev.feature * sample_ev.weight;

    // sample counter and done flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (clear) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (sample_ev.valid) begin
            cnt <= cnt + 1'b1;
            // the 25th sample closes the window
            if (cnt == cnt_w'(window_len - 1)) begin
                done <= 1'b1;
            end
        end
    end

    // lane accumulators, wrap at acc_w bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (sample_ev.valid) begin
            for (int i = 0; i < lane_n; i++) begin
                if (buff_en[i]) begin
                    // size cast keeps the sign of the product
                    acc[i] <= acc[i] + acc_w'(product);
                end
            end
        end
    end

    assign status = '{done: done, cnt: cnt};

endmodule

// ==== axil_read_port.sv ====
module axil_read_port #(
    parameter int acc_w = 20
) (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic [cnn_pkg::addr_w-1:0]                   araddr,
    input  logic                                         arvalid,
    output logic                                         arready,
    output logic [31:0]                                  rdata,
    output logic [1:0]                                   rresp,
    output logic                                         rvalid,
    input  logic                                         rready,
    input  logic signed [cnn_pkg::lane_n-1:0][acc_w-1:0] acc,
    input  cnn_pkg::status_s                             status
);
    import cnn_pkg::*;

    localparam int lane_idx_w = $clog2(lane_n);

    logic                  rd_accept;
    logic [addr_w-1:0]     acc_offset;
    logic                  acc_hit;
    logic [lane_idx_w-1:0] lane_idx;
    logic [31:0]           rd_data_nxt;
    logic [1:0]            rd_resp_nxt;

    // one read in flight, rvalid doubles as the busy flag
    assign arready   = !rvalid;
    assign rd_accept = arvalid && arready;

    // accumulator window is word aligned, lane_n words long
    assign acc_offset = araddr - reg_acc_base_addr;
    assign acc_hit    = (araddr >= reg_acc_base_addr) &&
                        (acc_offset < addr_w'(4 * lane_n)) &&
                        (araddr[1:0] == 2'b00);
    assign lane_idx   = acc_offset[2 +: lane_idx_w];

    always_comb begin
        rd_data_nxt = '0;
        rd_resp_nxt = resp_okay;
        if (araddr == reg_status_addr) begin
            // done in bit 8, count in the low bits
            rd_data_nxt[8]         = status.done;
            rd_data_nxt[cnt_w-1:0] = status.cnt;
        end else if (acc_hit) begin
            rd_data_nxt = 32'($signed(acc[lane_idx]));
        end else begin
            // unmapped or write only, zero data
            rd_resp_nxt = resp_slverr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // response payload captured at acceptance, held while rvalid waits
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data_nxt;
            rresp <= rd_resp_nxt;
        end
    end

endmodule

// ==== conv_window_top.sv ====
module conv_window_top #(
    parameter int acc_w = 20
) (
    input  logic                       clk,
    input  logic                       arst_n,
    // write address and data
    input  logic [cnn_pkg::addr_w-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic                       wvalid,
    output logic                       wready,
    // write response
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // read address and data
    input  logic [cnn_pkg::addr_w-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    import cnn_pkg::*;

    sample_ev_s                            sample_ev;
    logic                                  clear;
    status_s                               status;
    logic signed [lane_n-1:0][acc_w-1:0]   acc;

    // input side, bus writes become sample events and clears
    axil_write_port wr_port_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (data_word_u'(wdata)),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .status    (status),
        .sample_ev (sample_ev),
        .clear     (clear)
    );

    // processing part
    window_mac_array #(.acc_w(acc_w)) mac_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sample_ev (sample_ev),
        .clear     (clear),
        .acc       (acc),
        .status    (status)
    );

    // output side, sums and status back to the host
    axil_read_port #(.acc_w(acc_w)) rd_port_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .acc     (acc),
        .status  (status)
    );

endmodule

// ==== conv_window_properties.sv ====
module conv_window_properties (
    input logic                clk,
    input logic                arst_n,
    input logic                bvalid,
    input logic                bready,
    input logic                rvalid,
    input logic                rready,
    input cnn_pkg::sample_ev_s sample_ev,
    input cnn_pkg::status_s    status
);
    import cnn_pkg::*;

    // raised by any failing rule, watched from the testbench
    logic violation = 1'b0;

    // a pending write response stays up until the host takes it
    bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid)
        else begin
            violation = 1'b1;
            $error("bvalid dropped before bready was seen");
        end

    // same rule on the read data channel
    rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid)
        else begin
            violation = 1'b1;
            $error("rvalid dropped before rready was seen");
        end

    // one accepted write gives a single cycle strobe
    ev_single: assert property (@(posedge clk) disable iff (!arst_n)
        sample_ev.valid |=> !sample_ev.valid)
        else begin
            violation = 1'b1;
            $error("sample event valid held for two cycles");
        end

    // counter saturates at the window length
    cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
        status.cnt <= cnt_w'(window_len))
        else begin
            violation = 1'b1;
            $error("sample count ran past the window length");
        end

endmodule

bind conv_window_top conv_window_properties props_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .sample_ev (sample_ev),
    .status    (status)
);

// ==== tb_conv_window.sv ====
module tb_conv_window;
    import cnn_pkg::*;

    localparam int clk_period = 40;
    localparam int rec_words  = 512;
    // cycles granted to each replayed record
    localparam int rec_budget = 40;

    logic              clk;
    logic              arst_n;
    logic [addr_w-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [31:0]       wdata;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [addr_w-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;

    // four words per record, kind addr data resp
    logic [31:0] recs [rec_words];
    int          n_rec = 0;

    conv_window_top #(.acc_w(20)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERROR %s expected 0x%08h got 0x%08h", name, exp, got);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // called on a rising edge, returns on the edge of the response handshake
    task automatic write_reg(input logic [addr_w-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int gap;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!awready);
        // data channel is taken in the same cycle as the address
        check_value("wready", 32'd1, 32'(wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // host stalls the response for a few cycles
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        bready <= 1'b1;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [addr_w-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int gap;
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        rready <= 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    initial begin
        logic [31:0] got_data;
        logic [1:0]  got_resp;
        void'($urandom(32'hbe82_cdab));
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        $readmemh("conv_window_input.txt", recs);
        // records run up to the first kind 0 entry
        while (n_rec < rec_words / 4 &&
               (recs[4*n_rec] === 32'd1 || recs[4*n_rec] === 32'd2)) begin
            n_rec++;
        end
        assert (n_rec > 0 && n_rec < rec_words / 4 && recs[4*n_rec] === 32'd0) else begin
            $display("stimulus file is empty, has an unknown record kind or lacks its end");
            $display("Test failed");
            $fatal(1);
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < n_rec; i++) begin
            if (recs[4*i] === 32'd1) begin
                write_reg(recs[4*i+1][addr_w-1:0], recs[4*i+2], got_resp);
                check_value("bresp", recs[4*i+3], 32'(got_resp));
            end else begin
                read_reg(recs[4*i+1][addr_w-1:0], got_data, got_resp);
                check_value("rdata", recs[4*i+2], got_data);
                check_value("rresp", recs[4*i+3], 32'(got_resp));
            end
        end
        if (dut_i.props_i.violation) begin
            $display("a protocol rule on the DUT was broken during the run");
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test passed");
            $finish;
        end
    end

    // stop at once when a bound assertion fires
    initial begin
        wait (dut_i.props_i.violation === 1'b1);
        $display("a protocol rule on the DUT was broken during the run");
        $display("Test failed");
        $fatal(1);
    end

    // time limit follows the record count plus the reset cycles
    initial begin
        wait (n_rec > 0);
        #(clk_period * (4 + rec_budget * n_rec));
        $display("watchdog expired before the bus replay finished");
        $display("Test failed");
        $fatal(1);
    end

endmodule

// ==== conv_window_input.txt ====
// records of four hex words, kind addr data resp
// kind 1 writes data and expects resp as bresp
// kind 2 reads and expects data as rdata and resp as rresp, kind 0 ends the replay
2 08 00000000 0  2 10 00000000 0  2 14 00000000 0  2 18 00000000 0  2 1c 00000000 0
1 00 00000201 0  1 00 00000202 0  1 00 00000203 0  1 00 00000204 0  1 00 00000205 0
1 00 00000206 0  1 00 00000207 0  1 00 00000208 0  1 00 00000209 0  1 00 0000020a 0
1 00 0000020b 0  1 00 0000020c 0  1 00 0000020d 0  1 00 0000020e 0  1 00 0000020f 0
1 00 00000210 0  1 00 00000211 0  1 00 00000212 0  1 00 00000213 0  1 00 00000214 0
1 00 00000215 0  1 00 00000216 0  1 00 00000217 0  1 00 00000218 0  1 00 00000219 0
2 08 00000119 0  2 10 00000118 0  2 14 00000112 0  2 18 000000d0 0  2 1c 00000168 0
1 00 00000263 2  2 08 00000119 0  2 10 00000118 0  2 1c 00000168 0  1 08 00000001 2
1 04 00000001 0  2 08 00000000 0  2 10 00000000 0  2 14 00000000 0  2 18 00000000 0
1 0c 00000000 2  2 1c 00000000 0  2 00 00000000 2  2 20 00000000 2  2 12 00000000 2
1 00 0000fd01 0  1 00 0000fd02 0  1 00 0000fd03 0  1 00 0000fd04 0  1 00 0000fd05 0
1 00 0000fd06 0  1 00 0000fd07 0  1 00 0000fd08 0  1 00 0000fd09 0  1 00 0000fd0a 0
1 00 0000fd0b 0  1 00 0000fd0c 0  1 00 0000fd0d 0  1 00 0000fd0e 0  1 00 0000fd0f 0
1 00 0000fd10 0  1 00 0000fd11 0  1 00 0000fd12 0  1 00 0000fd13 0  1 00 0000fd14 0
1 00 0000fd15 0  1 00 0000fd16 0  1 00 0000fd17 0  1 00 0000fd18 0  1 00 0000fd19 0
2 08 00000119 0  2 10 fffffe5c 0  2 14 fffffe65 0  2 18 fffffec8 0  2 1c fffffde4 0
1 04 00000000 0  2 08 00000119 0  2 1c fffffde4 0  0 00 00000000 0

// ==== filelist.f ====
cnn_pkg.sv
feature_weight_en_decoder.sv
axil_write_port.sv
window_mac_array.sv
axil_read_port.sv
conv_window_top.sv
conv_window_properties.sv
tb_conv_window.sv
